//--- src/rgmii_rx_pkg.sv
package rgmii_rx_pkg;

	////////////////////////////////////////
	// Widths

	localparam int NIBBLE_W = 4;
	localparam int OCTET_W  = 8;
	localparam int LSPEED_W = 2;

	// One RGMII data nibble, as seen on one clock edge
	typedef logic [NIBBLE_W-1:0] nibble_t;

	// One GMII byte
	typedef logic [OCTET_W-1:0] octet_t;

	// Link speed as carried in the in-band status symbol
	typedef logic [LSPEED_W-1:0] lspeed_t;

	////////////////////////////////////////
	// Codes and symbols

	// In-band speed encoding, data bits 2:1 of the gap symbol
	localparam lspeed_t LINK_SPEED_10M   = 2'd0;
	localparam lspeed_t LINK_SPEED_100M  = 2'd1;
	localparam lspeed_t LINK_SPEED_1000M = 2'd2;

	localparam octet_t PREAMBLE_OCTET      = 8'h55;
	localparam octet_t SFD_OCTET           = 8'hD5;
	// Seen during the gap with ctl_diff set
	localparam octet_t FALSE_CARRIER_OCTET = 8'h0E;

	////////////////////////////////////////
	// Bundles between stages

	// Rising and falling edge samples for one gmii_rxc cycle
	typedef struct packed {
		nibble_t rxd_rise;
		nibble_t rxd_fall;
		logic    ctl_rise;
		logic    ctl_fall;
	} rgmii_sample_t;

	// Capture stage output
	typedef struct packed {
		logic   en;
		logic   er;
		logic   ctl_diff;
		octet_t data;
	} rx_lane_t;

	// GMII after nibble assembly
	typedef struct packed {
		logic   en;
		logic   er;
		logic   dvalid;
		octet_t data;
	} gmii_bus_t;

	// Payload byte stream out of the framer
	typedef struct packed {
		logic   valid;
		logic   last;
		logic   error;
		octet_t data;
	} frame_byte_t;

	typedef enum logic [1:0] {
		FR_IDLE,
		FR_PREAMBLE,
		FR_PAYLOAD,
		FR_DROP
	} framer_state_t;

endpackage

//--- src/rgmii_rx_capture.sv
module rgmii_rx_capture (
	input  logic                      gmii_rxc,
	input  logic                      reset,
	input  rgmii_rx_pkg::rgmii_sample_t rgmii_in,
	output rgmii_rx_pkg::rx_lane_t      lane
);

	////////////////////////////////////////
	// Control decode

	// Rising edge carries enable
	// Falling edge carries enable XOR error
	logic ctl_diff_in;
	logic en_q;
	logic er_q;
	logic ctl_diff_q;

	assign ctl_diff_in = rgmii_in.ctl_rise ^ rgmii_in.ctl_fall;

	always_ff @(posedge gmii_rxc) begin
		if (reset) begin
			en_q       <= 1'b0;
			er_q       <= 1'b0;
			ctl_diff_q <= 1'b0;
		end else begin
			en_q       <= rgmii_in.ctl_rise;
			// Error only has meaning inside a frame
			er_q       <= ctl_diff_in & rgmii_in.ctl_rise;
			// Outside a frame this marks special gap symbols
			ctl_diff_q <= ctl_diff_in;
		end
	end

	////////////////////////////////////////
	// Data

	// Low nibble arrives on the rising edge
	rgmii_rx_pkg::octet_t data_q;

	always_ff @(posedge gmii_rxc) begin
		data_q <= {rgmii_in.rxd_fall, rgmii_in.rxd_rise};
	end

	always_comb begin
		lane.en       = en_q;
		lane.er       = er_q;
		lane.ctl_diff = ctl_diff_q;
		lane.data     = data_q;
	end

endmodule

//--- src/rgmii_inband_status.sv
module rgmii_inband_status (
	input  logic                   gmii_rxc,
	input  logic                   reset,
	input  rgmii_rx_pkg::rx_lane_t lane,
	output logic                   link_up,
	output rgmii_rx_pkg::lspeed_t  link_speed,
	output logic                   false_carrier
);

	////////////////////////////////////////
	// Gap symbol fields

	// Bit 0 is link state, bits 2:1 the speed code
	rgmii_rx_pkg::lspeed_t speed_code;
	logic                  speed_known;
	logic                  gap_status;
	logic                  gap_false_carrier;

	assign speed_code = lane.data[2:1];

	// Reserved code 3 leaves the last speed in place
	assign speed_known = (speed_code == rgmii_rx_pkg::LINK_SPEED_10M)  ||
	                     (speed_code == rgmii_rx_pkg::LINK_SPEED_100M) ||
	                     (speed_code == rgmii_rx_pkg::LINK_SPEED_1000M);

	// Plain gap cycle, status symbol
	assign gap_status = !lane.en && !lane.ctl_diff;

	// Gap cycle with the false carrier pattern
	assign gap_false_carrier = !lane.en && lane.ctl_diff &&
	                           (lane.data == rgmii_rx_pkg::FALSE_CARRIER_OCTET);

	////////////////////////////////////////
	// Status registers

	always_ff @(posedge gmii_rxc) begin
		if (reset) begin
			link_up       <= 1'b0;
			link_speed    <= rgmii_rx_pkg::LINK_SPEED_10M;
			false_carrier <= 1'b0;
		end else begin
			// Single cycle pulse per false carrier symbol
			false_carrier <= gap_false_carrier;

			if (gap_status) begin
				link_up <= lane.data[0];
				if (speed_known) begin
					link_speed <= speed_code;
				end
			end
		end
	end

endmodule

//--- src/rgmii_rx_assembler.sv
module rgmii_rx_assembler (
	input  logic                    gmii_rxc,
	input  logic                    reset,
	input  rgmii_rx_pkg::rx_lane_t  lane,
	input  rgmii_rx_pkg::lspeed_t   link_speed,
	output rgmii_rx_pkg::gmii_bus_t gmii
);

	////////////////////////////////////////
	// Nibble phase tracking

	logic                  gig_mode;
	logic                  en_q;
	logic                  phase;
	logic                  phase_cur;
	logic                  sof;
	rgmii_rx_pkg::nibble_t lo_nibble;
	logic                  lo_er;

	assign gig_mode = (link_speed == rgmii_rx_pkg::LINK_SPEED_1000M);

	// Start of frame forces the low nibble phase
	assign sof       = lane.en && !en_q;
	assign phase_cur = sof ? 1'b0 : phase;

	always_ff @(posedge gmii_rxc) begin
		if (reset) begin
			en_q  <= 1'b0;
			phase <= 1'b0;
		end else begin
			en_q <= lane.en;
			if (lane.en) begin
				phase <= !phase_cur;
			end
		end
	end

	// Low nibble and its error wait for the high half
	// Falling nibble is only a repeat at 10/100
	always_ff @(posedge gmii_rxc) begin
		if (lane.en && !phase_cur) begin
			lo_nibble <= lane.data[3:0];
			lo_er     <= lane.er;
		end
	end

	////////////////////////////////////////
	// Output register

	logic                 en_r;
	logic                 er_r;
	logic                 dvalid_r;
	rgmii_rx_pkg::octet_t data_r;

	always_ff @(posedge gmii_rxc) begin
		if (reset) begin
			en_r     <= 1'b0;
			er_r     <= 1'b0;
			dvalid_r <= 1'b0;
		end else begin
			en_r <= lane.en;
			if (gig_mode) begin
				// Full byte every cycle
				er_r     <= lane.er;
				dvalid_r <= lane.en;
			end else begin
				// Byte complete on the high nibble phase
				er_r     <= phase_cur ? (lo_er | lane.er) : lane.er;
				dvalid_r <= lane.en && phase_cur;
			end
		end
	end

	always_ff @(posedge gmii_rxc) begin
		data_r <= gig_mode ? lane.data : {lane.data[3:0], lo_nibble};
	end

	always_comb begin
		gmii.en     = en_r;
		gmii.er     = er_r;
		gmii.dvalid = dvalid_r;
		gmii.data   = data_r;
	end

endmodule

//--- src/gmii_rx_framer.sv
module gmii_rx_framer (
	input  logic                      gmii_rxc,
	input  logic                      reset,
	input  rgmii_rx_pkg::gmii_bus_t   gmii,
	output rgmii_rx_pkg::frame_byte_t rx_out
);

	rgmii_rx_pkg::framer_state_t state;

	// Holding register so the final byte can carry last
	logic                 hold_valid;
	rgmii_rx_pkg::octet_t hold_data;
	// Sticky frame error, preamble bytes included
	logic                 err_sticky;
	logic                 byte_in;

	logic                 out_valid;
	logic                 out_last;
	logic                 out_error;
	rgmii_rx_pkg::octet_t out_data;

	assign byte_in = gmii.en && gmii.dvalid;

	////////////////////////////////////////
	// Frame FSM

	always_ff @(posedge gmii_rxc) begin
		if (reset) begin
			state      <= rgmii_rx_pkg::FR_IDLE;
			hold_valid <= 1'b0;
			err_sticky <= 1'b0;
			out_valid  <= 1'b0;
			out_last   <= 1'b0;
			out_error  <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			out_error <= 1'b0;

			case (state)
				rgmii_rx_pkg::FR_IDLE: begin
					hold_valid <= 1'b0;
					// First byte must already be preamble
					if (byte_in) begin
						err_sticky <= gmii.er;
						if (gmii.data == rgmii_rx_pkg::PREAMBLE_OCTET) begin
							state <= rgmii_rx_pkg::FR_PREAMBLE;
						end else begin
							state <= rgmii_rx_pkg::FR_DROP;
						end
					end
				end

				rgmii_rx_pkg::FR_PREAMBLE: begin
					// Frame gone before the SFD, nothing to report
					if (!gmii.en) begin
						state <= rgmii_rx_pkg::FR_IDLE;
					end else if (gmii.dvalid) begin
						err_sticky <= err_sticky | gmii.er;
						if (gmii.data == rgmii_rx_pkg::SFD_OCTET) begin
							state <= rgmii_rx_pkg::FR_PAYLOAD;
						end else if (gmii.data != rgmii_rx_pkg::PREAMBLE_OCTET) begin
							state <= rgmii_rx_pkg::FR_DROP;
						end
					end
				end

				rgmii_rx_pkg::FR_PAYLOAD: begin
					if (!gmii.en) begin
						// End of frame flushes the held byte as last
						out_valid  <= hold_valid;
						out_last   <= hold_valid;
						out_error  <= hold_valid & err_sticky;
						hold_valid <= 1'b0;
						state      <= rgmii_rx_pkg::FR_IDLE;
					end else if (gmii.dvalid) begin
						// New byte pushes the held one out
						out_valid  <= hold_valid;
						hold_valid <= 1'b1;
						err_sticky <= err_sticky | gmii.er;
					end
				end

				rgmii_rx_pkg::FR_DROP: begin
					// Bad delimiter, wait out the frame
					if (!gmii.en) begin
						state <= rgmii_rx_pkg::FR_IDLE;
					end
				end

				default: begin
					state <= rgmii_rx_pkg::FR_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Payload path

	always_ff @(posedge gmii_rxc) begin
		if (state == rgmii_rx_pkg::FR_PAYLOAD && byte_in) begin
			hold_data <= gmii.data;
		end
		out_data <= hold_data;
	end

	always_comb begin
		rx_out.valid = out_valid;
		rx_out.last  = out_last;
		rx_out.error = out_error;
		rx_out.data  = out_data;
	end

endmodule

//--- src/rgmii_rx_top.sv
module rgmii_rx_top (
	input  logic                        gmii_rxc,
	input  logic                        reset,
	input  rgmii_rx_pkg::rgmii_sample_t rgmii_in,
	output logic                        link_up,
	output rgmii_rx_pkg::lspeed_t       link_speed,
	output logic                        false_carrier,
	output rgmii_rx_pkg::frame_byte_t   rx_out
);

	////////////////////////////////////////
	// Stage interconnect

	rgmii_rx_pkg::rx_lane_t  lane;
	rgmii_rx_pkg::gmii_bus_t gmii;

	// DDR samples to GMII control and byte
	rgmii_rx_capture rgmii_rx_capture_inst (
		.gmii_rxc (gmii_rxc),
		.reset    (reset),
		.rgmii_in (rgmii_in),
		.lane     (lane)
	);

	// Link state from gap symbols
	rgmii_inband_status rgmii_inband_status_inst (
		.gmii_rxc      (gmii_rxc),
		.reset         (reset),
		.lane          (lane),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier)
	);

	// Speed dependent byte rebuild
	rgmii_rx_assembler rgmii_rx_assembler_inst (
		.gmii_rxc   (gmii_rxc),
		.reset      (reset),
		.lane       (lane),
		.link_speed (link_speed),
		.gmii       (gmii)
	);

	// Preamble strip and payload delivery
	gmii_rx_framer gmii_rx_framer_inst (
		.gmii_rxc (gmii_rxc),
		.reset    (reset),
		.gmii     (gmii),
		.rx_out   (rx_out)
	);

endmodule

//--- tb/rgmii_rx_assertions.sv
module rgmii_rx_assertions (
	input logic                      gmii_rxc,
	input logic                      reset,
	input logic                      false_carrier,
	input rgmii_rx_pkg::frame_byte_t rx_out
);

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////
	// Output stream rules

	valid_known: assert property (@(posedge gmii_rxc) disable iff (reset)
		!$isunknown(rx_out.valid))
		else $error("rx_out.valid is unknown");

	// Last only ever rides on a real byte
	last_has_valid: assert property (@(posedge gmii_rxc) disable iff (reset)
		rx_out.last |-> rx_out.valid)
		else $error("rx_out.last without rx_out.valid");

	// Frame error is reported on the last byte only
	error_on_last: assert property (@(posedge gmii_rxc) disable iff (reset)
		rx_out.error |-> rx_out.last)
		else $error("rx_out.error without rx_out.last");

	fc_single_pulse: assert property (@(posedge gmii_rxc) disable iff (reset)
		false_carrier |=> !false_carrier)
		else $error("false_carrier high for two cycles");

endmodule

bind rgmii_rx_top rgmii_rx_assertions rgmii_rx_assertions_inst (
	.gmii_rxc      (gmii_rxc),
	.reset         (reset),
	.false_carrier (false_carrier),
	.rx_out        (rx_out)
);

//--- tb/rgmii_rx_tb.sv
module rgmii_rx_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD    = 8;
	localparam int PAYLOAD_LEN   = 64;
	// Seven preamble bytes and the SFD ahead of the payload
	localparam int FRAME_LEN     = PAYLOAD_LEN + 8;
	// Four gigabit frames, one 100M frame at two cycles per byte
	localparam int FRAME_CYCLES  = 4 * FRAME_LEN + 2 * FRAME_LEN;
	localparam int MARGIN_CYCLES = 400;
	localparam int WATCHDOG_NS   = (FRAME_CYCLES * 4 + MARGIN_CYCLES) * CLK_PERIOD;

	logic                        gmii_rxc;
	logic                        reset;
	rgmii_rx_pkg::rgmii_sample_t rgmii_in;
	logic                        link_up;
	rgmii_rx_pkg::lspeed_t       link_speed;
	logic                        false_carrier;
	rgmii_rx_pkg::frame_byte_t   rx_out;

	logic [31:0]               rng_state;
	// Status symbol driven on every idle cycle
	rgmii_rx_pkg::octet_t      gap_symbol;
	rgmii_rx_pkg::octet_t      payload[$];
	rgmii_rx_pkg::frame_byte_t rx_queue[$];
	int                        last_count  = 0;
	int                        fc_count    = 0;
	int                        error_count = 0;

	rgmii_rx_top rgmii_rx_top_inst (
		.gmii_rxc      (gmii_rxc),
		.reset         (reset),
		.rgmii_in      (rgmii_in),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier),
		.rx_out        (rx_out)
	);

	initial gmii_rxc = 1'b0;
	always #(CLK_PERIOD / 2) gmii_rxc = ~gmii_rxc;

	// Outputs settle after the rising edge, so sample on the falling one
	always @(negedge gmii_rxc) begin
		if (!reset && rx_out.valid) begin
			rx_queue.push_back(rx_out);
			if (rx_out.last) begin
				last_count++;
			end
		end
		if (!reset && false_carrier) begin
			fc_count++;
		end
	end

	////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic rgmii_rx_pkg::rgmii_sample_t make_sample(
		input rgmii_rx_pkg::nibble_t rise,
		input rgmii_rx_pkg::nibble_t fall,
		input logic                  ctl_rise,
		input logic                  ctl_fall
	);
		rgmii_rx_pkg::rgmii_sample_t s;
		s.rxd_rise = rise;
		s.rxd_fall = fall;
		s.ctl_rise = ctl_rise;
		s.ctl_fall = ctl_fall;
		return s;
	endfunction

	task automatic stop_on_error(input string line);
		error_count++;
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string test_name, input string what,
	                           input int expected, input int actual);
		assert (actual == expected)
			else stop_on_error($sformatf("** Error %s: %s expected %0h actual %0h",
			                             test_name, what, expected, actual));
	endtask

	task automatic drive_cycle(input rgmii_rx_pkg::rgmii_sample_t s);
		@(posedge gmii_rxc);
		#1;
		rgmii_in = s;
	endtask

	task automatic drive_gap(input int cycles);
		repeat (cycles) begin
			drive_cycle(make_sample(gap_symbol[3:0], gap_symbol[7:4], 1'b0, 1'b0));
		end
	endtask

	// Status symbol: bit 0 link up, bits 2:1 speed code
	task automatic set_speed(input rgmii_rx_pkg::lspeed_t code);
		gap_symbol = {5'b0, code, 1'b1};
		drive_gap(4);
	endtask

	task automatic build_payload();
		payload.delete();
		repeat (PAYLOAD_LEN) begin
			rng_state = xorshift32(rng_state);
			payload.push_back(rng_state[7:0]);
		end
	endtask

	// err_index marks one frame byte with er, -1 for none
	task automatic send_frame(input rgmii_rx_pkg::lspeed_t speed,
	                          input rgmii_rx_pkg::octet_t sfd, input int err_index);
		rgmii_rx_pkg::octet_t frame[$];
		logic                 cf;
		repeat (7) frame.push_back(rgmii_rx_pkg::PREAMBLE_OCTET);
		frame.push_back(sfd);
		foreach (payload[i]) frame.push_back(payload[i]);
		for (int i = 0; i < frame.size(); i++) begin
			// Falling control low with enable high signals er
			cf = (i == err_index) ? 1'b0 : 1'b1;
			if (speed == rgmii_rx_pkg::LINK_SPEED_1000M) begin
				drive_cycle(make_sample(frame[i][3:0], frame[i][7:4], 1'b1, cf));
			end else begin
				// Nibble repeated on both edges, low nibble first
				drive_cycle(make_sample(frame[i][3:0], frame[i][3:0], 1'b1, cf));
				drive_cycle(make_sample(frame[i][7:4], frame[i][7:4], 1'b1, cf));
			end
		end
	endtask

	task automatic wait_frame_end(input string test_name);
		int start;
		int cycles;
		start  = last_count;
		cycles = 0;
		while (last_count == start && cycles < 64) begin
			drive_gap(1);
			cycles++;
		end
		assert (last_count > start)
			else stop_on_error($sformatf("%s: no last byte within 64 cycles of frame end",
			                             test_name));
	endtask

	task automatic check_payload(input string test_name, input logic exp_error);
		rgmii_rx_pkg::frame_byte_t got;
		check_value(test_name, "byte count", PAYLOAD_LEN, rx_queue.size());
		for (int i = 0; i < PAYLOAD_LEN; i++) begin
			got = rx_queue[i];
			check_value(test_name, $sformatf("data[%0d]", i), int'(payload[i]), int'(got.data));
			check_value(test_name, $sformatf("last[%0d]", i),
			            int'(i == PAYLOAD_LEN - 1), int'(got.last));
			check_value(test_name, $sformatf("error[%0d]", i),
			            int'(exp_error && i == PAYLOAD_LEN - 1), int'(got.error));
		end
		rx_queue.delete();
	endtask

	////////////////////////////////////////
	// Directed tests

	// Sampled before any gap symbol can overwrite the reset state
	task automatic test_reset_values();
		check_value("test_reset_values", "link_up", 0, int'(link_up));
		check_value("test_reset_values", "link_speed", 0, int'(link_speed));
		check_value("test_reset_values", "false_carrier", 0, int'(false_carrier));
		check_value("test_reset_values", "rx_out.valid", 0, int'(rx_out.valid));
	endtask

	task automatic test_link_status();
		set_speed(rgmii_rx_pkg::LINK_SPEED_100M);
		check_value("test_link_status", "link_up", 1, int'(link_up));
		check_value("test_link_status", "speed 100M", 1, int'(link_speed));
		set_speed(rgmii_rx_pkg::LINK_SPEED_10M);
		check_value("test_link_status", "speed 10M", 0, int'(link_speed));
		set_speed(rgmii_rx_pkg::LINK_SPEED_1000M);
		check_value("test_link_status", "speed 1000M", 2, int'(link_speed));
		// Reserved code 3 keeps the gigabit setting
		set_speed(2'd3);
		check_value("test_link_status", "speed after code 3", 2, int'(link_speed));
	endtask

	task automatic test_gigabit();
		set_speed(rgmii_rx_pkg::LINK_SPEED_1000M);
		build_payload();
		send_frame(rgmii_rx_pkg::LINK_SPEED_1000M, rgmii_rx_pkg::SFD_OCTET, -1);
		wait_frame_end("test_gigabit");
		check_payload("test_gigabit", 1'b0);
	endtask

	task automatic test_fast_ethernet();
		set_speed(rgmii_rx_pkg::LINK_SPEED_100M);
		build_payload();
		send_frame(rgmii_rx_pkg::LINK_SPEED_100M, rgmii_rx_pkg::SFD_OCTET, -1);
		wait_frame_end("test_fast_ethernet");
		check_payload("test_fast_ethernet", 1'b0);
	endtask

	task automatic test_errors();
		int start;
		set_speed(rgmii_rx_pkg::LINK_SPEED_1000M);
		build_payload();
		// er on payload byte 10
		send_frame(rgmii_rx_pkg::LINK_SPEED_1000M, rgmii_rx_pkg::SFD_OCTET, 18);
		wait_frame_end("test_errors");
		check_payload("test_errors", 1'b1);
		start = fc_count;
		drive_cycle(make_sample(4'hE, 4'h0, 1'b0, 1'b1));
		drive_gap(4);
		check_value("test_errors", "false_carrier pulses", start + 1, fc_count);
	endtask

	task automatic test_bad_delimiter();
		build_payload();
		send_frame(rgmii_rx_pkg::LINK_SPEED_1000M, 8'h5D, -1);
		drive_gap(16);
		check_value("test_bad_delimiter", "bytes from bad frame", 0, rx_queue.size());
		build_payload();
		send_frame(rgmii_rx_pkg::LINK_SPEED_1000M, rgmii_rx_pkg::SFD_OCTET, -1);
		wait_frame_end("test_bad_delimiter");
		check_payload("test_bad_delimiter", 1'b0);
	endtask

	initial begin
		rng_state  = 32'h799f;
		gap_symbol = '0;
		reset      = 1'b1;
		rgmii_in   = '0;
		repeat (16) @(posedge gmii_rxc);
		#1;
		reset = 1'b0;
		test_reset_values();
		test_link_status();
		test_gigabit();
		test_fast_ethernet();
		test_errors();
		test_bad_delimiter();
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Run length bound from the frame cycles above
	initial begin
		#(WATCHDOG_NS);
		$display("Verification failed");
		$fatal(1, "Watchdog timeout after %0d ns", WATCHDOG_NS);
	end

endmodule

//--- compile.f
src/rgmii_rx_pkg.sv
src/rgmii_rx_capture.sv
src/rgmii_inband_status.sv
src/rgmii_rx_assembler.sv
src/gmii_rx_framer.sv
src/rgmii_rx_top.sv
tb/rgmii_rx_assertions.sv
tb/rgmii_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RGMII receive testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module rgmii_rx_tb \
	-f compile.f \
	-o rgmii_rx_sim

# A fatal stop still leaves the output for the search below
sim_output=$(./obj_dir/rgmii_rx_sim) || true
echo "$sim_output"

if echo "$sim_output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
